//--- Bender.yml
package:
  name: ipd

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/ipd_pkg.sv
      - logic/ipd_ctrl_if.sv
      - logic/ipd_fifo.sv
      - logic/ipd_regs.sv
      - logic/ipd_shaper.sv
      - logic/ipd_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - test/ipd_tb_sva.sv
      - test/ipd_tb.sv

//--- logic/ipd_ctrl_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Configuration from the register file
// host_reset is a single cycle pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ipd_params.svh"
`default_nettype none

interface ipd_ctrl_if (
   input wire axi_aclk
);
   import ipd_pkg::*;

   ipd_mode_e               mode;
   logic [`IPD_TIME_W-1:0]  delay;
   logic                    host_reset;

   modport regs (input axi_aclk, output mode, output delay, output host_reset);

   modport shaper (input axi_aclk, input mode, input delay, input host_reset);

endinterface

`default_nettype wire

//--- logic/ipd_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fall-through FIFO with registered flags
// Writes into a full FIFO are dropped
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ipd_params.svh"
`default_nettype none

module ipd_fifo #(
   parameter type T = ipd_pkg::beat_t
) (
   input wire   axi_aclk,
   input wire   rst_n,
   input wire   flush,
   input wire T din,
   input wire   wr_en,
   input wire   rd_en,
   output T     dout,
   output logic empty,
   output logic nearly_full
);

   localparam int unsigned depth = 1 << `IPD_FIFO_AW;
   // One free entry left
   localparam logic [`IPD_FIFO_AW:0] nf_level = {1'b0, {`IPD_FIFO_AW{1'b1}}};

   T mem [depth];

   logic [`IPD_FIFO_AW-1:0] wr_ptr;
   logic [`IPD_FIFO_AW-1:0] rd_ptr;
   logic [`IPD_FIFO_AW:0]   count_q;
   logic [`IPD_FIFO_AW:0]   count_d;
   logic                    do_wr;
   logic                    do_rd;

   // MSB of the count is set only when full
   assign do_wr = wr_en && !count_q[`IPD_FIFO_AW];
   assign do_rd = rd_en && !empty;

   // Head entry straight out of the array
   assign dout = mem[rd_ptr];

   always_comb begin
      count_d = count_q;
      if (do_wr && !do_rd) begin
         count_d = count_q + 1'b1;
      end else if (!do_wr && do_rd) begin
         count_d = count_q - 1'b1;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge axi_aclk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count_q     <= '0;
         empty       <= 1'b1;
         nearly_full <= 1'b0;
      end else if (flush) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count_q     <= '0;
         empty       <= 1'b1;
         nearly_full <= 1'b0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count_q     <= count_d;
         empty       <= (count_d == '0);
         nearly_full <= (count_d >= nf_level);
      end
   end

endmodule

`default_nettype wire

//--- logic/ipd_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizes and register map of the delay block
// Keep masks are low aligned and dense
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`ifndef IPD_PARAMS_SVH
`define IPD_PARAMS_SVH

// Stream beat
`define IPD_DATA_W 64
`define IPD_KEEP_W (`IPD_DATA_W/8)
`define IPD_HALF_W (`IPD_DATA_W/2)
`define IPD_USER_W 16

// Time base and input FIFO
`define IPD_TIME_W 32
`define IPD_FIFO_AW 2

// Register port
`define IPD_REG_AW 2
`define IPD_REG_DW 32
`define IPD_REG_CTRL 2'd0
`define IPD_REG_DELAY 2'd1
`define IPD_REG_RESET 2'd2

`endif
`default_nettype wire

//--- logic/ipd_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types shared by the delay block
// Sizes come from the params header
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "ipd_params.svh"
`default_nettype none

package ipd_pkg;

   // One beat of the packet stream
   typedef struct packed {
      logic [`IPD_DATA_W-1:0] data;
      logic [`IPD_KEEP_W-1:0] keep;
      logic [`IPD_USER_W-1:0] user;
      logic                   last;
   } beat_t;

   // Pacing mode decoded from CTRL
   // Bypass when enable is clear, otherwise use_reg picks the delay source
   typedef enum logic [1:0] {
      mode_bypass = 2'd0,
      mode_reg    = 2'd1,
      mode_hdr    = 2'd2
   } ipd_mode_e;

endpackage

`default_nettype wire

//--- logic/ipd_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file on a four-phase req/ack port
// One access per req. Unmapped addresses read 0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ipd_params.svh"
`default_nettype none

module ipd_regs (
   input wire                    axi_aclk,
   input wire                    rst_n,
   input wire                    reg_req,
   input wire                    reg_wr,
   input wire [`IPD_REG_AW-1:0]  reg_addr,
   input wire [`IPD_REG_DW-1:0]  reg_wdata,
   output logic                  reg_ack,
   output logic [`IPD_REG_DW-1:0] reg_rdata,
   ipd_ctrl_if.regs              ctrl
);
   import ipd_pkg::*;

   typedef enum logic {
      ack_idle,
      ack_busy
   } ack_state_e;

   ack_state_e              ack_state;
   logic                    access;
   logic                    ctrl_enable;
   logic                    ctrl_use_reg;
   logic [`IPD_TIME_W-1:0]  delay_q;
   logic                    host_reset_q;
   logic [`IPD_REG_DW-1:0]  rdata_mux;

   // Access happens once, on the edge that raises ack
   assign access  = (ack_state == ack_idle) && reg_req;
   assign reg_ack = (ack_state == ack_busy);

   always_comb begin
      rdata_mux = '0;
      case (reg_addr)
         `IPD_REG_CTRL: begin
            rdata_mux[0] = ctrl_enable;
            rdata_mux[1] = ctrl_use_reg;
         end
         `IPD_REG_DELAY: rdata_mux[`IPD_TIME_W-1:0] = delay_q;
         default: rdata_mux = '0;
      endcase
   end

   always_ff @(posedge axi_aclk or negedge rst_n) begin
      if (!rst_n) begin
         ack_state    <= ack_idle;
         ctrl_enable  <= 1'b0;
         ctrl_use_reg <= 1'b0;
         delay_q      <= '0;
         host_reset_q <= 1'b0;
      end else begin
         host_reset_q <= 1'b0;
         case (ack_state)
            ack_idle: begin
               if (reg_req) begin
                  ack_state <= ack_busy;
                  if (reg_wr) begin
                     case (reg_addr)
                        `IPD_REG_CTRL: begin
                           ctrl_enable  <= reg_wdata[0];
                           ctrl_use_reg <= reg_wdata[1];
                        end
                        `IPD_REG_DELAY: delay_q <= reg_wdata[`IPD_TIME_W-1:0];
                        `IPD_REG_RESET: host_reset_q <= 1'b1;
                        default: ;
                     endcase
                  end
               end
            end
            // Wait for the host to drop req
            ack_busy: begin
               if (!reg_req) begin
                  ack_state <= ack_idle;
               end
            end
            default: ack_state <= ack_idle;
         endcase
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (access) begin
         reg_rdata <= rdata_mux;
      end
   end

   assign ctrl.mode       = !ctrl_enable ? mode_bypass : (ctrl_use_reg ? mode_reg : mode_hdr);
   assign ctrl.delay      = delay_q;
   assign ctrl.host_reset = host_reset_q;

endmodule

`default_nettype wire

//--- logic/ipd_shaper.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Paces first beats of packets by a gap
// Header mode needs a full first beat
// The time counter wraps after 2^IPD_TIME_W cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ipd_params.svh"
`default_nettype none

module ipd_shaper (
   input wire                axi_aclk,
   input wire                rst_n,
   ipd_ctrl_if.shaper        ctrl,
   input wire ipd_pkg::beat_t s_beat,
   input wire                s_tvalid,
   output logic              s_tready,
   output ipd_pkg::beat_t    fifo_din,
   output logic              fifo_wr_en,
   input wire ipd_pkg::beat_t fifo_dout,
   input wire                fifo_empty,
   input wire                fifo_nearly_full,
   output logic              fifo_rd_en,
   output ipd_pkg::beat_t    m_beat,
   output logic              m_tvalid,
   input wire                m_tready
);
   import ipd_pkg::*;

   typedef enum logic {
      st_hdr,
      st_in_pkt
   } pace_state_e;

   pace_state_e            state_q;
   pace_state_e            state_d;
   logic [`IPD_TIME_W-1:0] tcount_q;
   logic [`IPD_TIME_W-1:0] last_ts_q;
   logic [`IPD_TIME_W-1:0] leave_time_q;
   logic [`IPD_TIME_W-1:0] cur_delay;
   logic                   first_done_q;
   logic                   leave_rdy_q;
   logic                   hdr_avail;
   logic                   go;
   logic                   first_xfer;

   // Realignment buffer for header mode
   beat_t                  buf_q;
   logic                   buf_valid_q;
   logic                   buf_valid_d;
   logic                   buf_load;
   beat_t                  merged;
   logic                   merged_avail;

   assign go = leave_rdy_q && (tcount_q >= leave_time_q);

   // Upper half of the buffered beat joined with lower half of the FIFO head
   always_comb begin
      merged = '0;
      merged.user = buf_q.user;
      merged.data[`IPD_HALF_W-1:0] = buf_q.data[`IPD_DATA_W-1:`IPD_HALF_W];
      merged.keep[`IPD_KEEP_W/2-1:0] = buf_q.keep[`IPD_KEEP_W-1:`IPD_KEEP_W/2];
      if (buf_q.last) begin
         merged.last  = 1'b1;
         merged_avail = buf_valid_q;
      end else begin
         merged.data[`IPD_DATA_W-1:`IPD_HALF_W] = fifo_dout.data[`IPD_HALF_W-1:0];
         merged.keep[`IPD_KEEP_W-1:`IPD_KEEP_W/2] = fifo_dout.keep[`IPD_KEEP_W/2-1:0];
         // Ends here when the next beat has nothing in its upper half
         merged.last  = fifo_dout.last && !fifo_dout.keep[`IPD_KEEP_W/2];
         merged_avail = buf_valid_q && !fifo_empty;
      end
   end

   always_comb begin
      fifo_din    = s_beat;
      fifo_wr_en  = s_tvalid && !fifo_nearly_full;
      s_tready    = !fifo_nearly_full;
      m_beat      = fifo_dout;
      m_tvalid    = 1'b0;
      fifo_rd_en  = 1'b0;
      buf_load    = 1'b0;
      buf_valid_d = buf_valid_q;
      hdr_avail   = 1'b0;
      cur_delay   = ctrl.delay;
      case (ctrl.mode)
         mode_reg: begin
            hdr_avail  = !fifo_empty;
            m_tvalid   = !fifo_empty && ((state_q == st_in_pkt) || go);
            fifo_rd_en = m_tvalid && m_tready;
         end
         mode_hdr: begin
            cur_delay = buf_q.data[`IPD_TIME_W-1:0];
            hdr_avail = buf_valid_q;
            m_beat    = merged;
            m_tvalid  = merged_avail && ((state_q == st_in_pkt) || go);
            if (!buf_valid_q) begin
               buf_load    = !fifo_empty;
               fifo_rd_en  = !fifo_empty;
               buf_valid_d = !fifo_empty;
            end else if (m_tvalid && m_tready) begin
               buf_load   = !fifo_empty;
               fifo_rd_en = !fifo_empty;
               if (buf_q.last) begin
                  // FIFO head is the next packet and was not merged
                  buf_valid_d = !fifo_empty;
               end else begin
                  buf_valid_d = !merged.last;
               end
            end
         end
         default: begin
            fifo_wr_en = 1'b0;
            s_tready   = m_tready;
            m_beat     = s_beat;
            m_tvalid   = s_tvalid;
         end
      endcase
   end

   assign first_xfer = (ctrl.mode != mode_bypass) && (state_q == st_hdr) &&
                       m_tvalid && m_tready;

   always_comb begin
      state_d = state_q;
      if ((ctrl.mode != mode_bypass) && m_tvalid && m_tready) begin
         if (state_q == st_hdr && !m_beat.last) begin
            state_d = st_in_pkt;
         end else if (state_q == st_in_pkt && m_beat.last) begin
            state_d = st_hdr;
         end
      end
   end

   always_ff @(posedge axi_aclk or negedge rst_n) begin
      if (!rst_n) begin
         state_q      <= st_hdr;
         tcount_q     <= '0;
         last_ts_q    <= '0;
         leave_time_q <= '0;
         first_done_q <= 1'b0;
         leave_rdy_q  <= 1'b0;
         buf_valid_q  <= 1'b0;
      end else if (ctrl.host_reset) begin
         state_q      <= st_hdr;
         tcount_q     <= '0;
         last_ts_q    <= '0;
         leave_time_q <= '0;
         first_done_q <= 1'b0;
         leave_rdy_q  <= 1'b0;
         buf_valid_q  <= 1'b0;
      end else begin
         state_q     <= state_d;
         tcount_q    <= tcount_q + 1'b1;
         buf_valid_q <= buf_valid_d;
         if (first_xfer) begin
            last_ts_q    <= tcount_q;
            first_done_q <= 1'b1;
            leave_rdy_q  <= 1'b0;
         end else if (state_q == st_hdr && !leave_rdy_q && hdr_avail) begin
            // No previous departure means no wait
            leave_time_q <= first_done_q ? last_ts_q + cur_delay : '0;
            leave_rdy_q  <= 1'b1;
         end
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (buf_load) begin
         buf_q <= fifo_dout;
      end
   end

endmodule

`default_nettype wire

//--- logic/ipd_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Inter-packet delay block
// Single clock. Mode changes only between packets
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ipd_params.svh"
`default_nettype none

module ipd_top (
   input wire                     axi_aclk,
   input wire                     rst_n,
   // Slave stream
   input wire [`IPD_DATA_W-1:0]   s_tdata,
   input wire [`IPD_KEEP_W-1:0]   s_tkeep,
   input wire [`IPD_USER_W-1:0]   s_tuser,
   input wire                     s_tlast,
   input wire                     s_tvalid,
   output logic                   s_tready,
   // Master stream
   output logic [`IPD_DATA_W-1:0] m_tdata,
   output logic [`IPD_KEEP_W-1:0] m_tkeep,
   output logic [`IPD_USER_W-1:0] m_tuser,
   output logic                   m_tlast,
   output logic                   m_tvalid,
   input wire                     m_tready,
   // Register port
   input wire                     reg_req,
   input wire                     reg_wr,
   input wire [`IPD_REG_AW-1:0]   reg_addr,
   input wire [`IPD_REG_DW-1:0]   reg_wdata,
   output logic                   reg_ack,
   output logic [`IPD_REG_DW-1:0] reg_rdata
);
   import ipd_pkg::*;

   beat_t s_beat;
   beat_t m_beat;
   beat_t fifo_din;
   beat_t fifo_dout;
   logic  fifo_wr_en;
   logic  fifo_rd_en;
   logic  fifo_empty;
   logic  fifo_nearly_full;

   assign s_beat.data = s_tdata;
   assign s_beat.keep = s_tkeep;
   assign s_beat.user = s_tuser;
   assign s_beat.last = s_tlast;

   assign m_tdata = m_beat.data;
   assign m_tkeep = m_beat.keep;
   assign m_tuser = m_beat.user;
   assign m_tlast = m_beat.last;

   ipd_ctrl_if i_ctrl_if (.axi_aclk(axi_aclk));

   ipd_regs i_ipd_regs (
      .axi_aclk  (axi_aclk),
      .rst_n     (rst_n),
      .reg_req   (reg_req),
      .reg_wr    (reg_wr),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .reg_ack   (reg_ack),
      .reg_rdata (reg_rdata),
      .ctrl      (i_ctrl_if.regs)
   );

   // Host reset also empties the input FIFO
   ipd_fifo #(.T(beat_t)) i_ipd_fifo (
      .axi_aclk    (axi_aclk),
      .rst_n       (rst_n),
      .flush       (i_ctrl_if.host_reset),
      .din         (fifo_din),
      .wr_en       (fifo_wr_en),
      .rd_en       (fifo_rd_en),
      .dout        (fifo_dout),
      .empty       (fifo_empty),
      .nearly_full (fifo_nearly_full)
   );

   ipd_shaper i_ipd_shaper (
      .axi_aclk         (axi_aclk),
      .rst_n            (rst_n),
      .ctrl             (i_ctrl_if.shaper),
      .s_beat           (s_beat),
      .s_tvalid         (s_tvalid),
      .s_tready         (s_tready),
      .fifo_din         (fifo_din),
      .fifo_wr_en       (fifo_wr_en),
      .fifo_dout        (fifo_dout),
      .fifo_empty       (fifo_empty),
      .fifo_nearly_full (fifo_nearly_full),
      .fifo_rd_en       (fifo_rd_en),
      .m_beat           (m_beat),
      .m_tvalid         (m_tvalid),
      .m_tready         (m_tready)
   );

endmodule

`default_nettype wire

//--- sim.f
+incdir+logic
logic/ipd_pkg.sv
logic/ipd_ctrl_if.sv
logic/ipd_fifo.sv
logic/ipd_regs.sv
logic/ipd_shaper.sv
logic/ipd_top.sv
test/ipd_tb_sva.sv
test/ipd_tb.sv

//--- test/ipd_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Random packets in every mode against a queue model
// Mode changes and host resets only while idle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ipd_params.svh"
`default_nettype none

module ipd_tb;
   import ipd_pkg::*;

   logic                    axi_aclk;
   logic                    rst_n;
   logic [`IPD_DATA_W-1:0]  s_tdata;
   logic [`IPD_KEEP_W-1:0]  s_tkeep;
   logic [`IPD_USER_W-1:0]  s_tuser;
   logic                    s_tlast;
   logic                    s_tvalid;
   logic                    s_tready;
   logic [`IPD_DATA_W-1:0]  m_tdata;
   logic [`IPD_KEEP_W-1:0]  m_tkeep;
   logic [`IPD_USER_W-1:0]  m_tuser;
   logic                    m_tlast;
   logic                    m_tvalid;
   logic                    m_tready;
   logic                    reg_req;
   logic                    reg_wr;
   logic [`IPD_REG_AW-1:0]  reg_addr;
   logic [`IPD_REG_DW-1:0]  reg_wdata;
   logic                    reg_ack;
   logic [`IPD_REG_DW-1:0]  reg_rdata;

   logic [31:0] rng;
   int          mismatch_cnt = 0;
   int          other_cnt = 0;
   int          cycle = 0;
   string       cur_test = "reset";
   ipd_mode_e   cur_mode = mode_bypass;
   int          cur_delay = 0;
   bit          stall_en = 0;
   bit          pace_check = 0;
   bit          have_prev = 0;
   int          prev_dep = 0;
   int          max_latency = -1;
   beat_t       src_q[$];
   beat_t       exp_q[$];
   int          need_q[$];
   int          acc_q[$];
   event        end_run;

   ipd_top i_ipd_top (.*);

   initial begin
      axi_aclk = 1'b0;
      forever #2 axi_aclk = ~axi_aclk;
   end

   // Xorshift32
   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   function automatic logic [`IPD_KEEP_W-1:0] low_keep(input int k);
      logic [15:0] m;
      m = (16'd1 << k) - 16'd1;
      return m[`IPD_KEEP_W-1:0];
   endfunction

   function automatic logic [`IPD_DATA_W-1:0] byte_mask(input logic [`IPD_KEEP_W-1:0] keep);
      logic [`IPD_DATA_W-1:0] m;
      int i;
      for (i = 0; i < `IPD_KEEP_W; i++) begin
         m[8*i +: 8] = {8{keep[i]}};
      end
      return m;
   endfunction

   task automatic compare(input string name, input logic [63:0] expected,
                          input logic [63:0] actual);
      if (expected !== actual) begin
         mismatch_cnt++;
         $display("mismatch %s expected %h actual %h", name, expected, actual);
      end
   endtask

   // Four-phase access, each phase bounded
   task automatic reg_access(input logic wr, input logic [`IPD_REG_AW-1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      int n;
      @(negedge axi_aclk);
      reg_req   = 1'b1;
      reg_wr    = wr;
      reg_addr  = addr;
      reg_wdata = wdata;
      n = 0;
      while (reg_ack !== 1'b1 && n < 16) begin
         @(posedge axi_aclk);
         n++;
      end
      if (reg_ack !== 1'b1) begin
         other_cnt++;
         $display("register access to address %0d got no ack", addr);
         -> end_run;
      end
      rdata = reg_rdata;
      @(negedge axi_aclk);
      reg_req = 1'b0;
      n = 0;
      while (reg_ack !== 1'b0 && n < 16) begin
         @(posedge axi_aclk);
         n++;
      end
      if (reg_ack !== 1'b0) begin
         other_cnt++;
         $display("ack stayed high after req dropped");
         -> end_run;
      end
   endtask

   task automatic set_mode(input ipd_mode_e mode, input int delay);
      logic [31:0] rd;
      cur_mode   = mode;
      cur_delay  = delay;
      pace_check = (mode != mode_bypass);
      reg_access(1'b1, `IPD_REG_DELAY, delay, rd);
      reg_access(1'b1, `IPD_REG_CTRL, (mode == mode_reg) ? 3 : ((mode == mode_hdr) ? 1 : 0), rd);
      reg_access(1'b1, `IPD_REG_RESET, 32'd0, rd);
      have_prev = 0;
   endtask

   // Input beats plus expected output beats for one packet
   task automatic gen_packet();
      beat_t       pkt [6];
      beat_t       ob;
      int          n, k, total, out_n, b, i, j;
      logic [31:0] hdr_delay;
      logic [31:0] r;
      n = 1 + next_rand() % 6;
      k = 1 + next_rand() % 8;
      hdr_delay = next_rand() % 41;
      if (cur_mode == mode_hdr && n == 1) begin
         k = 8;
      end
      for (i = 0; i < n; i++) begin
         pkt[i].keep = (i == n - 1) ? low_keep(k) : '1;
         pkt[i].data = {next_rand(), next_rand()} & byte_mask(pkt[i].keep);
         r = next_rand();
         pkt[i].user = r[`IPD_USER_W-1:0];
         pkt[i].last = (i == n - 1);
         if (cur_mode == mode_hdr && i == 0) begin
            pkt[i].data[31:0] = hdr_delay;
         end
         src_q.push_back(pkt[i]);
      end
      if (cur_mode == mode_hdr) begin
         // Drop the 4 header bytes and repack
         total = 8 * (n - 1) + k - 4;
         out_n = (total + 7) / 8;
         for (i = 0; i < out_n; i++) begin
            ob = '0;
            for (j = 0; j < 8; j++) begin
               b = 8 * i + j + 4;
               if (b < total + 4) begin
                  ob.data[8*j +: 8] = pkt[b / 8].data[8 * (b % 8) +: 8];
                  ob.keep[j] = 1'b1;
               end
            end
            ob.user = pkt[i].user;
            ob.last = (i == out_n - 1);
            exp_q.push_back(ob);
         end
         need_q.push_back(hdr_delay);
      end else begin
         for (i = 0; i < n; i++) begin
            exp_q.push_back(pkt[i]);
         end
         need_q.push_back(cur_delay);
      end
   endtask

   task automatic run_packets(input string name, input int npkts, input bit stall);
      int n;
      cur_test = name;
      stall_en = stall;
      repeat (npkts) gen_packet();
      n = 0;
      while ((src_q.size() != 0 || exp_q.size() != 0) && n < npkts * 400) begin
         @(posedge axi_aclk);
         n++;
      end
      if (src_q.size() != 0 || exp_q.size() != 0) begin
         other_cnt++;
         $display("%s: stream did not drain within %0d cycles", name, n);
         -> end_run;
      end
      stall_en = 0;
   endtask

   // Source and sink driving on the falling edge
   initial begin : drive_stream
      forever begin
         @(posedge axi_aclk);
         if (s_tvalid && s_tready) begin
            src_q.delete(0);
         end
         @(negedge axi_aclk);
         m_tready = stall_en ? ((next_rand() % 4) != 0) : 1'b1;
         s_tvalid = (src_q.size() != 0);
         if (src_q.size() != 0) begin
            s_tdata = src_q[0].data;
            s_tkeep = src_q[0].keep;
            s_tuser = src_q[0].user;
            s_tlast = src_q[0].last;
         end
      end
   end

   initial begin : watch_stream
      beat_t exp_beat;
      bit    in_first;
      bit    out_first;
      int    need;
      int    acc;
      in_first  = 1'b1;
      out_first = 1'b1;
      forever begin
         @(posedge axi_aclk);
         cycle++;
         if (rst_n) begin
            if (cur_mode == mode_bypass) begin
               compare({cur_test, " s_tready"}, m_tready, s_tready);
            end
            if (s_tvalid && s_tready) begin
               if (in_first) begin
                  acc_q.push_back(cycle);
               end
               in_first = s_tlast;
            end
            if (m_tvalid && m_tready) begin
               if (exp_q.size() == 0) begin
                  other_cnt++;
                  $display("%s: output beat with none expected", cur_test);
               end else begin
                  exp_beat = exp_q.pop_front();
                  compare({cur_test, " data"}, exp_beat.data,
                          m_tdata & byte_mask(exp_beat.keep));
                  compare({cur_test, " keep"}, exp_beat.keep, m_tkeep);
                  compare({cur_test, " user"}, exp_beat.user, m_tuser);
                  compare({cur_test, " last"}, exp_beat.last, m_tlast);
                  if (out_first) begin
                     need = need_q.pop_front();
                     acc  = acc_q.pop_front();
                     if (pace_check && have_prev && (cycle - prev_dep) < need) begin
                        other_cnt++;
                        $display("%s: packet left %0d cycles after the previous one, gap is %0d",
                                 cur_test, cycle - prev_dep, need);
                     end
                     if (max_latency >= 0 && (cycle - acc) > max_latency) begin
                        other_cnt++;
                        $display("%s: packet waited %0d cycles after a host reset",
                                 cur_test, cycle - acc);
                     end
                     prev_dep  = cycle;
                     have_prev = 1'b1;
                  end
                  out_first = m_tlast;
               end
            end
         end
      end
   end

   initial begin : report
      int sva_cnt;
      @(end_run);
      sva_cnt = i_ipd_top.i_ipd_tb_sva.fail_cnt;
      $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
               mismatch_cnt, other_cnt, sva_cnt);
      if (mismatch_cnt == 0 && other_cnt == 0 && sva_cnt == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   initial begin : main
      logic [31:0] rd;
      rng       = 32'd68906;
      rst_n     = 1'b0;
      s_tdata   = '0;
      s_tkeep   = '0;
      s_tuser   = '0;
      s_tlast   = 1'b0;
      s_tvalid  = 1'b0;
      m_tready  = 1'b1;
      reg_req   = 1'b0;
      reg_wr    = 1'b0;
      reg_addr  = '0;
      reg_wdata = '0;
      repeat (10) @(posedge axi_aclk);
      @(negedge axi_aclk);
      rst_n = 1'b1;

      cur_test = "regs";
      reg_access(1'b1, `IPD_REG_CTRL, 32'd3, rd);
      reg_access(1'b0, `IPD_REG_CTRL, 32'd0, rd);
      compare("regs ctrl", 32'd3, rd);
      reg_access(1'b1, `IPD_REG_DELAY, 32'h5a3c_0f21, rd);
      reg_access(1'b0, `IPD_REG_DELAY, 32'd0, rd);
      compare("regs delay", 32'h5a3c_0f21, rd);
      reg_access(1'b0, `IPD_REG_RESET, 32'd0, rd);
      compare("regs reset", 32'd0, rd);
      reg_access(1'b0, 2'd3, 32'd0, rd);
      compare("regs unmapped", 32'd0, rd);

      set_mode(mode_bypass, 0);
      run_packets("bypass", 12, 1'b1);
      set_mode(mode_reg, next_rand() % 41);
      run_packets("reg", 12, 1'b1);
      set_mode(mode_hdr, 0);
      run_packets("hdr", 12, 1'b1);

      // Second packet must not wait for the 40 cycle gap
      set_mode(mode_reg, 40);
      run_packets("host_reset_a", 1, 1'b0);
      reg_access(1'b1, `IPD_REG_RESET, 32'd1, rd);
      have_prev   = 0;
      max_latency = 4;
      run_packets("host_reset_b", 1, 1'b0);
      max_latency = -1;
      reg_access(1'b0, `IPD_REG_CTRL, 32'd0, rd);
      compare("host_reset ctrl", 32'd3, rd);
      reg_access(1'b0, `IPD_REG_DELAY, 32'd0, rd);
      compare("host_reset delay", 32'd40, rd);

      repeat (20) @(posedge axi_aclk);
      -> end_run;
   end

endmodule

`default_nettype wire

//--- test/ipd_tb_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Handshake assertions bound into ipd_top
// host_reset is taken from the ctrl interface
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ipd_params.svh"
`default_nettype none

module ipd_tb_sva (
   input wire                   axi_aclk,
   input wire                   rst_n,
   input wire [`IPD_DATA_W-1:0] m_tdata,
   input wire [`IPD_KEEP_W-1:0] m_tkeep,
   input wire [`IPD_USER_W-1:0] m_tuser,
   input wire                   m_tlast,
   input wire                   m_tvalid,
   input wire                   m_tready,
   input wire                   reg_req,
   input wire                   reg_ack,
   input wire                   host_reset
);

   // Number of assertion failures so far
   int fail_cnt = 0;

   // Output beat holds while the sink stalls
   a_out_hold: assert property (@(posedge axi_aclk) disable iff (!rst_n)
      m_tvalid && !m_tready |=> m_tvalid && $stable({m_tdata, m_tkeep, m_tuser, m_tlast}))
      else begin
         $error("output beat changed or dropped valid while stalled");
         fail_cnt++;
      end

   a_ack_after_req: assert property (@(posedge axi_aclk) disable iff (!rst_n)
      $rose(reg_ack) |-> $past(reg_req))
      else begin
         $error("ack rose without a pending req");
         fail_cnt++;
      end

   a_reset_pulse: assert property (@(posedge axi_aclk) disable iff (!rst_n)
      host_reset |=> !host_reset)
      else begin
         $error("host_reset high for more than one cycle");
         fail_cnt++;
      end

endmodule

bind ipd_top ipd_tb_sva i_ipd_tb_sva (
   .axi_aclk   (axi_aclk),
   .rst_n      (rst_n),
   .m_tdata    (m_tdata),
   .m_tkeep    (m_tkeep),
   .m_tuser    (m_tuser),
   .m_tlast    (m_tlast),
   .m_tvalid   (m_tvalid),
   .m_tready   (m_tready),
   .reg_req    (reg_req),
   .reg_ack    (reg_ack),
   .host_reset (i_ctrl_if.host_reset)
);

`default_nettype wire
